// ==== source/icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// fetch address split into tag, index and byte offset
`define ICACHE_ADDR_SIZE 16
`define ICACHE_OFFSET_SIZE 3
`define ICACHE_INDEX_SIZE 5
`define ICACHE_TAG_SIZE 8

// 32 sets of two ways
`define ICACHE_SET_NUM (1 << `ICACHE_INDEX_SIZE)
`define ICACHE_WAY 2

// one fetch block
`define ICACHE_BLOCK_SIZE 64

// response tag from memory, zero means refused or no data
`define ICACHE_MEM_TAG_SIZE 4

// blocks the prefetcher may run ahead of the demand block
`define ICACHE_PREFETCH_DEPTH 4

`endif

// ==== source/icache_pkg.sv ====
`default_nettype none
`include "icache_config.svh"

package icache_pkg;

	// address as seen by the array lookup
	typedef struct packed {
		logic [`ICACHE_TAG_SIZE-1:0]    tag;
		logic [`ICACHE_INDEX_SIZE-1:0]  index;
		logic [`ICACHE_OFFSET_SIZE-1:0] offset;
	} addr_fields_t;

	// raw word for pointer arithmetic, fields for lookup
	typedef union packed {
		logic [`ICACHE_ADDR_SIZE-1:0] raw;
		addr_fields_t                 fields;
	} icache_addr_u;

	typedef enum logic [1:0] {
		NONE = 2'd0,
		LOAD = 2'd1
	} mem_command_e;

	// address is always block aligned
	typedef struct packed {
		mem_command_e                 command;
		logic [`ICACHE_ADDR_SIZE-1:0] addr;
	} mem_request_t;

	// response answers this cycle's request, tag marks returning data
	typedef struct packed {
		logic [`ICACHE_MEM_TAG_SIZE-1:0] response;
		logic [`ICACHE_MEM_TAG_SIZE-1:0] tag;
		logic [`ICACHE_BLOCK_SIZE-1:0]   data;
	} mem_reply_t;

	typedef struct packed {
		logic [`ICACHE_TAG_SIZE-1:0]   tag;
		logic [`ICACHE_INDEX_SIZE-1:0] index;
		logic                          enable;
	} cache_lookup_t;

endpackage

`default_nettype wire

// ==== source/icache_mem.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_config.svh"

module icache_mem (
	input wire logic                      clock,
	input wire logic                      reset,
	input wire icache_pkg::cache_lookup_t demand_lookup,
	input wire icache_pkg::cache_lookup_t prefetch_lookup,
	input wire icache_pkg::cache_lookup_t load_lookup,
	input wire icache_pkg::mem_reply_t    mem_reply,
	output logic                          demand_hit,
	output logic [`ICACHE_BLOCK_SIZE-1:0] demand_data,
	output logic                          prefetch_hit,
	output logic                          load_in_flight,
	output logic                          victim_busy
);

	// storage, one entry per set and way
	logic [`ICACHE_TAG_SIZE-1:0]          tag_array  [`ICACHE_SET_NUM][`ICACHE_WAY];
	logic [`ICACHE_BLOCK_SIZE-1:0]        data_array [`ICACHE_SET_NUM][`ICACHE_WAY];
	logic [`ICACHE_MEM_TAG_SIZE-1:0]      pending    [`ICACHE_SET_NUM][`ICACHE_WAY];
	logic [`ICACHE_SET_NUM-1:0][`ICACHE_WAY-1:0] valid;

	// points at the way to replace next
	logic [`ICACHE_SET_NUM-1:0]           lru;

	logic [`ICACHE_WAY-1:0]               demand_match;
	logic [`ICACHE_WAY-1:0]               prefetch_match;
	logic [`ICACHE_WAY-1:0]               load_match;
	logic [`ICACHE_WAY-1:0]               load_busy;
	logic                                 demand_way;
	logic                                 victim_way;
	logic                                 load_accept;
	logic [`ICACHE_SET_NUM-1:0][`ICACHE_WAY-1:0] fill_match;

	// tag compare over the ways of the addressed set
	function automatic logic [`ICACHE_WAY-1:0] tag_match(
		input icache_pkg::cache_lookup_t lookup
	);
		logic [`ICACHE_WAY-1:0] match;
		for (int w = 0; w < `ICACHE_WAY; w++)
		begin
			match[w] = tag_array[lookup.index][w] == lookup.tag;
		end
		return match;
	endfunction

	// demand and prefetch lookups only count filled ways
	always_comb
	begin
		demand_match = tag_match(demand_lookup) & valid[demand_lookup.index]
			& {`ICACHE_WAY{demand_lookup.enable}};
		prefetch_match = tag_match(prefetch_lookup) & valid[prefetch_lookup.index]
			& {`ICACHE_WAY{prefetch_lookup.enable}};
	end

	always_comb
	begin
		demand_way = 1'b0;
		for (int w = 0; w < `ICACHE_WAY; w++)
		begin
			if (demand_match[w])
			begin
				demand_way = w[0];
			end
		end
	end

	assign demand_hit = |demand_match;
	assign demand_data = demand_hit ? data_array[demand_lookup.index][demand_way] : '0;
	assign prefetch_hit = |prefetch_match;

	// load target state, independent of the load enable
	always_comb
	begin
		for (int w = 0; w < `ICACHE_WAY; w++)
		begin
			load_busy[w] = pending[load_lookup.index][w] != '0;
		end
		load_match = tag_match(load_lookup) & load_busy;
	end

	assign victim_way = lru[load_lookup.index];
	assign load_in_flight = |load_match;
	assign victim_busy = load_busy[victim_way];

	// memory took the load when it answered with a tag
	assign load_accept = load_lookup.enable && mem_reply.response != '0;

	// returning data finds its way by the pending response tag
	always_comb
	begin
		for (int s = 0; s < `ICACHE_SET_NUM; s++)
		begin
			for (int w = 0; w < `ICACHE_WAY; w++)
			begin
				fill_match[s][w] = mem_reply.tag != '0 && pending[s][w] == mem_reply.tag;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			lru <= '0;
			for (int s = 0; s < `ICACHE_SET_NUM; s++)
			begin
				for (int w = 0; w < `ICACHE_WAY; w++)
				begin
					pending[s][w] <= '0;
				end
			end
		end
		else
		begin
			for (int s = 0; s < `ICACHE_SET_NUM; s++)
			begin
				for (int w = 0; w < `ICACHE_WAY; w++)
				begin
					if (fill_match[s][w])
					begin
						valid[s][w] <= 1'b1;
						pending[s][w] <= '0;
					end
				end
			end
			// recently used way is kept
			if (demand_hit)
			begin
				lru[demand_lookup.index] <= ~demand_way;
			end
			// victim way never has a fill pending here, so no clash with the loop
			if (load_accept)
			begin
				valid[load_lookup.index][victim_way] <= 1'b0;
				pending[load_lookup.index][victim_way] <= mem_reply.response;
				lru[load_lookup.index] <= ~victim_way;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		for (int s = 0; s < `ICACHE_SET_NUM; s++)
		begin
			for (int w = 0; w < `ICACHE_WAY; w++)
			begin
				if (fill_match[s][w])
				begin
					data_array[s][w] <= mem_reply.data;
				end
			end
		end
		if (load_accept)
		begin
			tag_array[load_lookup.index][victim_way] <= load_lookup.tag;
		end
	end

endmodule

`default_nettype wire

// ==== source/icache_controller.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_config.svh"

module icache_controller (
	input wire logic                     clock,
	input wire logic                     reset,
	input wire logic                     fetch_enable,
	input wire icache_pkg::icache_addr_u fetch_pc,
	input wire logic                     demand_hit,
	input wire logic                     prefetch_hit,
	input wire logic                     load_in_flight,
	input wire logic                     victim_busy,
	input wire icache_pkg::mem_reply_t   mem_reply,
	output icache_pkg::cache_lookup_t    demand_lookup,
	output icache_pkg::cache_lookup_t    prefetch_lookup,
	output icache_pkg::cache_lookup_t    load_lookup,
	output icache_pkg::mem_request_t     mem_request
);

	localparam int BLOCK_BITS = `ICACHE_ADDR_SIZE - `ICACHE_OFFSET_SIZE;
	localparam logic [`ICACHE_ADDR_SIZE-1:0] BLOCK_STEP = 1 << `ICACHE_OFFSET_SIZE;
	localparam logic [BLOCK_BITS-1:0] DEPTH = BLOCK_BITS'(`ICACHE_PREFETCH_DEPTH);

	icache_pkg::icache_addr_u     demand_block;
	icache_pkg::icache_addr_u     pref_addr;
	icache_pkg::icache_addr_u     target_addr;
	icache_pkg::icache_addr_u     held_addr;
	icache_pkg::icache_addr_u     load_addr;
	logic                         pref_valid;
	logic [`ICACHE_ADDR_SIZE-1:0] distance_raw;
	logic [BLOCK_BITS-1:0]        distance;
	logic                         in_window;
	logic                         target_valid;
	logic                         held_valid;
	logic                         load_ready;
	logic                         issue;
	logic                         load_accept;
	logic                         prefetch_accept;

	// demand address with the byte offset dropped
	always_comb
	begin
		demand_block = fetch_pc;
		demand_block.fields.offset = '0;
	end

	assign demand_lookup.tag = demand_block.fields.tag;
	assign demand_lookup.index = demand_block.fields.index;
	assign demand_lookup.enable = fetch_enable;

	// how many blocks the pointer runs ahead of the demand block
	assign distance_raw = pref_addr.raw - demand_block.raw;
	assign distance = distance_raw[`ICACHE_ADDR_SIZE-1:`ICACHE_OFFSET_SIZE];
	assign in_window = pref_valid && distance != '0 && distance <= DEPTH;

	assign prefetch_lookup.tag = pref_addr.fields.tag;
	assign prefetch_lookup.index = pref_addr.fields.index;
	assign prefetch_lookup.enable = fetch_enable && in_window;

	// demand miss wins over prefetch miss
	always_comb
	begin
		target_valid = 1'b0;
		target_addr = demand_block;
		if (demand_lookup.enable && !demand_hit)
		begin
			target_valid = 1'b1;
		end
		else if (prefetch_lookup.enable && !prefetch_hit)
		begin
			target_valid = 1'b1;
			target_addr = pref_addr;
		end
	end

	// a refused load is replayed unchanged
	assign load_addr = held_valid ? held_addr : target_addr;
	assign issue = load_ready
		&& (held_valid || (target_valid && !load_in_flight && !victim_busy));
	assign load_accept = issue && mem_reply.response != '0;
	assign prefetch_accept = load_accept && load_addr.raw == pref_addr.raw;

	assign load_lookup.tag = load_addr.fields.tag;
	assign load_lookup.index = load_addr.fields.index;
	assign load_lookup.enable = issue;

	assign mem_request.command = issue ? icache_pkg::LOAD : icache_pkg::NONE;
	assign mem_request.addr = load_addr.raw;

	// holds off loads for the first cycle out of reset
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			load_ready <= 1'b0;
		end
		else
		begin
			load_ready <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			held_valid <= 1'b0;
		end
		else
		begin
			held_valid <= issue && mem_reply.response == '0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (issue && mem_reply.response == '0)
		begin
			held_addr <= load_addr;
		end
	end

	// prefetch pointer, restarts when the demand leaves the window
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pref_valid <= 1'b0;
			pref_addr <= '0;
		end
		else if (fetch_enable && !in_window)
		begin
			pref_valid <= 1'b1;
			pref_addr.raw <= demand_block.raw + BLOCK_STEP;
		end
		else if (prefetch_lookup.enable && (prefetch_hit || prefetch_accept)
			&& distance < DEPTH)
		begin
			pref_addr.raw <= pref_addr.raw + BLOCK_STEP;
		end
	end

endmodule

`default_nettype wire

// ==== source/icache.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_config.svh"

module icache (
	input wire logic                      clock,
	input wire logic                      reset,
	input wire logic                      fetch_enable,
	input wire icache_pkg::icache_addr_u  fetch_pc,
	input wire icache_pkg::mem_reply_t    mem_reply,
	output wire logic                     fetch_valid,
	output wire [`ICACHE_BLOCK_SIZE-1:0]  fetch_data,
	output icache_pkg::mem_request_t      mem_request
);

	// controller to array lookups
	icache_pkg::cache_lookup_t demand_lookup;
	icache_pkg::cache_lookup_t prefetch_lookup;
	icache_pkg::cache_lookup_t load_lookup;

	// array status back to the controller
	wire logic demand_hit;
	wire logic prefetch_hit;
	wire logic load_in_flight;
	wire logic victim_busy;

	icache_controller controller (
		.clock           (clock),
		.reset           (reset),
		.fetch_enable    (fetch_enable),
		.fetch_pc        (fetch_pc),
		.demand_hit      (demand_hit),
		.prefetch_hit    (prefetch_hit),
		.load_in_flight  (load_in_flight),
		.victim_busy     (victim_busy),
		.mem_reply       (mem_reply),
		.demand_lookup   (demand_lookup),
		.prefetch_lookup (prefetch_lookup),
		.load_lookup     (load_lookup),
		.mem_request     (mem_request)
	);

	icache_mem memory (
		.clock           (clock),
		.reset           (reset),
		.demand_lookup   (demand_lookup),
		.prefetch_lookup (prefetch_lookup),
		.load_lookup     (load_lookup),
		.mem_reply       (mem_reply),
		.demand_hit      (demand_hit),
		.demand_data     (fetch_data),
		.prefetch_hit    (prefetch_hit),
		.load_in_flight  (load_in_flight),
		.victim_busy     (victim_busy)
	);

	// a hit is the only way to valid fetch data
	assign fetch_valid = demand_hit;

endmodule

`default_nettype wire

// ==== verif/icache_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_config.svh"

module icache_assertions (
	input wire logic                                        clock,
	input wire logic                                        reset,
	input wire logic                                        fetch_enable,
	input wire logic                                        fetch_valid,
	input wire icache_pkg::mem_request_t                    mem_request,
	input wire logic [`ICACHE_SET_NUM-1:0][`ICACHE_WAY-1:0] fill_match
);

	// failure count read by the testbench at the end
	int failures = 0;

	// no load while reset holds or in the cycle after it
	no_load_in_reset: assert property (@(posedge clock)
		reset |=> mem_request.command == icache_pkg::NONE)
	else
	begin
		failures++;
		$error("LOAD issued during reset or right after it");
	end

	aligned_load: assert property (@(posedge clock) disable iff (reset)
		mem_request.command == icache_pkg::LOAD
		|-> mem_request.addr[`ICACHE_OFFSET_SIZE-1:0] == '0)
	else
	begin
		failures++;
		$error("LOAD address %h is not block aligned", mem_request.addr);
	end

	// a returning tag fills one way at most
	single_fill: assert property (@(posedge clock) disable iff (reset)
		$onehot0(fill_match))
	else
	begin
		failures++;
		$error("reply tag matches more than one pending way");
	end

	valid_needs_enable: assert property (@(posedge clock) disable iff (reset)
		fetch_valid |-> fetch_enable)
	else
	begin
		failures++;
		$error("fetch_valid without fetch_enable");
	end

endmodule

`default_nettype wire

// ==== verif/icache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_config.svh"

module icache_tb;

	localparam int AW = `ICACHE_ADDR_SIZE;
	// limit well above the roughly 600 cycles the tests take
	localparam int MAX_CYCLES = 4000;
	localparam int WALK_BLOCKS = 20;

	logic                          clock;
	logic                          reset;
	logic                          fetch_enable;
	icache_pkg::icache_addr_u      fetch_pc;
	icache_pkg::mem_reply_t        mem_reply;
	logic                          fetch_valid;
	logic [`ICACHE_BLOCK_SIZE-1:0] fetch_data;
	icache_pkg::mem_request_t      mem_request;

	int     errors = 0;
	int     cycles = 0;
	integer seed = 32'h2a23_64fa;
	bit     refusals_on = 1'b0;

	// one memory model slot per response tag
	logic [AW-1:0] slot_addr [1:15];
	int            slot_due  [1:15];
	bit            slot_busy [1:15];
	logic [3:0]    next_tag = 4'd1;
	int            load_count [logic [AW-1:0]];
	bit            delivered  [logic [AW-1:0]];

	bind icache icache_assertions checks (
		.clock        (clock),
		.reset        (reset),
		.fetch_enable (fetch_enable),
		.fetch_valid  (fetch_valid),
		.mem_request  (mem_request),
		.fill_match   (memory.fill_match)
	);

	icache uut (
		.clock        (clock),
		.reset        (reset),
		.fetch_enable (fetch_enable),
		.fetch_pc     (fetch_pc),
		.mem_reply    (mem_reply),
		.fetch_valid  (fetch_valid),
		.fetch_data   (fetch_data),
		.mem_request  (mem_request)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: tests did not finish in %0d cycles, %0d errors", MAX_CYCLES, errors);
			$display("Test failed");
			$finish;
		end
	end

	task automatic report_error(input string what, input logic [AW-1:0] addr);
		errors++;
		$display("** Error at %0t: %s, block %h", $time, what, addr);
	endtask

	// block address xored with the quarter number in each 16-bit quarter
	function automatic logic [`ICACHE_BLOCK_SIZE-1:0] block_data(input logic [AW-1:0] block);
		return {block ^ 16'd3, block ^ 16'd2, block ^ 16'd1, block};
	endfunction

	function automatic int loads_of(input logic [AW-1:0] block);
		return load_count.exists(block) ? load_count[block] : 0;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic check_idle();
		assert (!fetch_valid && mem_request.command == icache_pkg::NONE)
		else report_error("fetch_valid or LOAD around reset", mem_request.addr);
	endtask

	// hold one address until it hits, then keep it for dwell more cycles
	task automatic fetch_block(input logic [AW-1:0] pc, input bit must_hit, input int dwell);
		logic [AW-1:0] block;
		block = pc & 16'hfff8;
		next_cycle();
		fetch_enable = 1'b1;
		fetch_pc.raw = pc;
		@(negedge clock);
		assert (fetch_valid || !must_hit)
		else report_error("no hit for a block that is in the cache", block);
		while (!fetch_valid)
		begin
			next_cycle();
			@(negedge clock);
		end
		assert (delivered.exists(block))
		else report_error("fetch_valid before memory returned the block", block);
		for (int i = 0; i <= dwell; i++)
		begin
			if (i > 0)
			begin
				next_cycle();
				@(negedge clock);
			end
			assert (fetch_valid)
			else report_error("fetch_valid dropped on a held block", block);
			assert (fetch_data == block_data(block))
			else report_error($sformatf("data %h, expected %h", fetch_data, block_data(block)),
				block);
		end
	endtask

	// returns data 1 ns and answers loads 2 ns after the edge
	initial
	begin
		bit            refused_last;
		logic [AW-1:0] refused_addr;
		refused_last = 1'b0;
		refused_addr = '0;
		mem_reply = '0;
		forever
		begin
			next_cycle();
			mem_reply = '0;
			for (int t = 1; t < 16; t++)
			begin
				if (slot_busy[t] && slot_due[t] <= cycles && mem_reply.tag == '0)
				begin
					mem_reply.tag = 4'(t);
					mem_reply.data = block_data(slot_addr[t]);
					delivered[slot_addr[t]] = 1'b1;
					slot_busy[t] = 1'b0;
				end
			end
			#1;
			if (mem_request.command == icache_pkg::LOAD)
			begin
				assert (!refused_last || mem_request.addr == refused_addr)
				else report_error("refused load replayed with a new address", mem_request.addr);
				refused_last = refusals_on && ($random(seed) & 3) == 0;
				refused_addr = mem_request.addr;
				if (!refused_last)
				begin
					mem_reply.response = next_tag;
					slot_addr[next_tag] = mem_request.addr;
					slot_due[next_tag] = cycles + 6 + int'($unsigned($random(seed)) % 5);
					slot_busy[next_tag] = 1'b1;
					load_count[mem_request.addr] = loads_of(mem_request.addr) + 1;
					next_tag = next_tag == 4'd15 ? 4'd1 : next_tag + 4'd1;
				end
			end
			else
			begin
				assert (!refused_last)
				else report_error("refused load was dropped", refused_addr);
				refused_last = 1'b0;
			end
		end
	end

	initial
	begin
		logic [AW-1:0] walk_addr;
		reset = 1'b1;
		// a fetch that misses is already pending while reset holds
		fetch_enable = 1'b1;
		fetch_pc.raw = 16'h1004;
		repeat (15)
		begin
			@(negedge clock);
			check_idle();
		end
		next_cycle();
		reset = 1'b0;
		@(negedge clock);
		check_idle();

		// cold miss
		fetch_block(16'h1004, 1'b0, 2);

		// sequential walk with the prefetcher running ahead
		for (int b = 0; b < WALK_BLOCKS; b++)
		begin
			walk_addr = 16'h2000 + 16'(b * 8);
			assert (b == 0 || loads_of(walk_addr) == 1)
			else report_error("block not prefetched before its demand", walk_addr);
			fetch_block(walk_addr, 1'b0, 4);
		end
		for (int b = 0; b < WALK_BLOCKS; b++)
		begin
			walk_addr = 16'h2000 + 16'(b * 8);
			assert (loads_of(walk_addr) == 1)
			else report_error("block loaded more than once", walk_addr);
		end

		// block of the cold miss hits again after other blocks
		fetch_block(16'h1000, 1'b1, 0);
		assert (loads_of(16'h1000) == 1)
		else report_error("a hit caused another load", 16'h1000);

		// three blocks of set 31 with the first one ending up as the victim
		fetch_block(16'h30f8, 1'b0, 1);
		fetch_block(16'h31f8, 1'b0, 1);
		fetch_block(16'h32f8, 1'b0, 1);
		fetch_block(16'h30f8, 1'b0, 1);
		assert (loads_of(16'h30f8) == 2)
		else report_error("evicted block was not loaded again", 16'h30f8);
		fetch_block(16'h32f8, 1'b1, 0);
		assert (loads_of(16'h32f8) == 1)
		else report_error("most recently used block was replaced", 16'h32f8);

		// memory refuses at random
		refusals_on = 1'b1;
		for (int b = 0; b < 12; b++)
		begin
			fetch_block(16'h5000 + 16'(b * 8), 1'b0, 2);
		end
		refusals_on = 1'b0;

		next_cycle();
		fetch_enable = 1'b0;
		$display("errors: %0d from checks, %0d from assertions", errors, uut.checks.failures);
		if (errors == 0 && uut.checks.failures == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/icache_pkg.sv
source/icache_mem.sv
source/icache_controller.sv
source/icache.sv
verif/icache_assertions.sv
verif/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the icache testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module icache_tb -o icache_sim \
	&& sim_output="$(./obj_dir/icache_sim)"
echo "$sim_output"
echo "$sim_output" | grep -qx "Test passed" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
